/* verilog/raster_pkg.sv */
package raster_pkg;

    localparam int FRAC_BITS = 16;             // Fraction bits of the Q16.16 format.

    typedef logic signed [31:0] fixed;        // Signed Q16.16 number.

    localparam fixed FIXED_MAX = 32'h7FFF_FFFF;
    localparam fixed FIXED_MIN = 32'h8000_0000;

    typedef struct packed {
        fixed x;
        fixed y;
    } position_t;

    typedef struct packed {
        position_t position;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic [15:0] id;                       // Triangle count since reset, wraps.
        logic        end_of_mesh;
    } triangle_metadata_t;

    typedef struct packed {
        triangle_t          triangle;
        triangle_metadata_t metadata;
    } triangle_item_t;

    typedef struct packed {
        triangle_t triangle;
        fixed      area_inv;
    } attributed_triangle_t;

    function automatic fixed add(fixed a, fixed b);
        return a + b;                          // Wraps at 32 bits.
    endfunction

    function automatic fixed sub(fixed a, fixed b);
        return a - b;
    endfunction

    function automatic fixed mul(fixed a, fixed b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] product;
        wide_a  = a;
        wide_b  = b;
        product = wide_a * wide_b;
        // Arithmetic shift floors toward minus infinity.
        return fixed'(product >>> FRAC_BITS);
    endfunction

    function automatic fixed itof(int value);
        return fixed'(value << FRAC_BITS);
    endfunction

    // Twice the signed area, positive for counter-clockwise order.
    function automatic fixed triangle_area(position_t p0, position_t p1, position_t p2);
        fixed term0;
        fixed term1;
        fixed term2;
        term0 = mul(sub(p1.y, p2.y), p0.x);
        term1 = mul(sub(p2.y, p0.y), p1.x);
        term2 = mul(sub(p0.y, p1.y), p2.x);
        return add(add(term0, term1), term2);
    endfunction

endpackage

/* verilog/triangle_assembler.sv */
`timescale 1ns/1ps

module triangle_assembler import raster_pkg::*; (
    input  logic           clk,
    input  logic           rstn,

    input  logic           vertex_s_valid,
    output logic           vertex_s_ready,
    input  vertex_t        vertex_s_data,
    input  logic           vertex_s_last,

    input  logic           item_ready,
    output logic           item_valid,
    output triangle_item_t item_data
);

    logic [1:0]  slot;                         // Next vertex position, 0 to 2.
    logic [15:0] next_id;
    vertex_t     vertex0;
    vertex_t     vertex1;
    logic        vertex_fire;
    logic        third_vertex;

    // Input stalls only while a finished triangle is still waiting.
    assign vertex_s_ready = !item_valid || item_ready;
    assign vertex_fire    = vertex_s_valid && vertex_s_ready;
    assign third_vertex   = vertex_fire && (slot == 2'd2);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot       <= 2'd0;
            next_id    <= 16'd0;
            item_valid <= 1'b0;
        end else begin
            if (vertex_fire) begin
                slot <= (slot == 2'd2) ? 2'd0 : slot + 2'd1;
            end

            if (third_vertex) begin
                item_valid <= 1'b1;
                next_id    <= next_id + 16'd1;   // Wraps at 16 bits.
            end else if (item_ready) begin
                item_valid <= 1'b0;
            end
        end
    end

    // Vertex storage and the outgoing triangle.
    always_ff @(posedge clk) begin
        if (vertex_fire && slot == 2'd0) begin
            vertex0 <= vertex_s_data;
        end
        if (vertex_fire && slot == 2'd1) begin
            vertex1 <= vertex_s_data;
        end
        if (third_vertex) begin
            item_data.triangle.v0           <= vertex0;
            item_data.triangle.v1           <= vertex1;
            item_data.triangle.v2           <= vertex_s_data;
            item_data.metadata.id           <= next_id;
            item_data.metadata.end_of_mesh  <= vertex_s_last;  // Sampled with the third vertex only.
        end
    end

endmodule

/* verilog/triangle_fifo.sv */
`timescale 1ns/1ps

module triangle_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rstn,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;                 // Number of stored entries.
    logic               push;
    logic               pop;

    assign in_ready  = (count != COUNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leave the count unchanged.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* verilog/fixed_divider.sv */
`timescale 1ns/1ps

module fixed_divider import raster_pkg::*; (
    input  logic clk,
    input  logic rstn,

    input  fixed dividend_data,

    input  logic divisor_valid,
    input  fixed divisor_data,

    output logic result_valid,
    output fixed result_data
);

    localparam int NUM_W      = 32 + FRAC_BITS;  // Width of the shifted dividend.
    localparam int ITERATIONS = NUM_W;

    logic              busy;
    logic [5:0]        step;                     // Iterations done so far.
    logic [NUM_W-1:0]  quotient;                 // Numerator shifts out, quotient bits shift in.
    logic [31:0]       remainder;
    logic [31:0]       denominator;
    logic              negative;

    logic [31:0]       dividend_mag;
    logic [31:0]       divisor_mag;
    logic [32:0]       rem_shift;
    logic              rem_fits;

    // Magnitudes fit in 32 unsigned bits, FIXED_MIN included.
    assign dividend_mag = dividend_data[31] ? 32'(-dividend_data) : 32'(dividend_data);
    assign divisor_mag  = divisor_data[31] ? 32'(-divisor_data) : 32'(divisor_data);

    assign rem_shift = {remainder, quotient[NUM_W-1]};
    assign rem_fits  = (rem_shift >= {1'b0, denominator});

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy         <= 1'b0;
            step         <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;                // Single-cycle pulse.
            if (!busy) begin
                if (divisor_valid) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else if (step == 6'(ITERATIONS)) begin
                busy         <= 1'b0;
                result_valid <= 1'b1;
            end else begin
                step <= step + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            if (divisor_valid) begin
                quotient    <= {dividend_mag, FRAC_BITS'(0)};
                remainder   <= '0;
                denominator <= divisor_mag;
                negative    <= dividend_data[31] ^ divisor_data[31];
            end
        end else if (step == 6'(ITERATIONS)) begin
            // Saturate on zero divisor or a quotient beyond 32 bits.
            if (denominator == '0) begin
                result_data <= negative ? FIXED_MIN : FIXED_MAX;
            end else if (!negative && quotient > NUM_W'(32'h7FFF_FFFF)) begin
                result_data <= FIXED_MAX;
            end else if (negative && quotient > NUM_W'(32'h8000_0000)) begin
                result_data <= FIXED_MIN;
            end else if (negative) begin
                result_data <= -fixed'(quotient[31:0]);
            end else begin
                result_data <= fixed'(quotient[31:0]);
            end
        end else begin
            // One restoring step per cycle.
            if (rem_fits) begin
                remainder <= 32'(rem_shift - {1'b0, denominator});
            end else begin
                remainder <= rem_shift[31:0];
            end
            quotient <= {quotient[NUM_W-2:0], rem_fits};
        end
    end

endmodule

/* verilog/triangle_preprocessor.sv */
`timescale 1ns/1ps

module triangle_preprocessor import raster_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,

    output logic                 triangle_s_ready,
    input  logic                 triangle_s_valid,
    input  triangle_item_t       triangle_s_data,

    input  logic                 attributed_triangle_m_ready,
    output logic                 attributed_triangle_m_valid,
    output attributed_triangle_t attributed_triangle_m_data,
    output triangle_metadata_t   attributed_triangle_m_metadata
);

    typedef enum logic [2:0] {
        IDLE,                                  // Waiting for a triangle.
        CALCULATE_AREA,                        // Area terms settle.
        LATCH_AREA,                            // Area registered, divider started.
        CALCULATE_INVERSE,                     // Waiting on the divider.
        DONE                                   // Holding the result until taken.
    } preprocessor_state_t;

    preprocessor_state_t state;
    preprocessor_state_t state_next;

    triangle_item_t item;
    fixed           area_c;
    fixed           area_r;
    fixed           area_inv;
    logic           area_inv_valid;
    logic           accept;
    logic           release_out;

    assign triangle_s_ready            = (state == IDLE);
    assign attributed_triangle_m_valid = (state == DONE);

    assign accept      = triangle_s_valid && triangle_s_ready;
    assign release_out = attributed_triangle_m_valid && attributed_triangle_m_ready;

    assign area_c = triangle_area(
        item.triangle.v0.position,
        item.triangle.v1.position,
        item.triangle.v2.position
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = CALCULATE_AREA;
                end
            end
            CALCULATE_AREA: begin
                state_next = LATCH_AREA;
            end
            LATCH_AREA: begin
                state_next = CALCULATE_INVERSE;  // Divider takes the area this cycle.
            end
            CALCULATE_INVERSE: begin
                if (area_inv_valid) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                if (release_out) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item <= triangle_s_data;
        end
        if (state == CALCULATE_AREA) begin
            area_r <= area_c;
        end
        if (area_inv_valid) begin
            attributed_triangle_m_data.triangle <= item.triangle;
            attributed_triangle_m_data.area_inv <= area_inv;
            attributed_triangle_m_metadata      <= item.metadata;
        end
    end

    fixed_divider divider (
        .clk           (clk),
        .rstn          (rstn),
        .dividend_data (itof(1)),              // Computes 1 / area.
        .divisor_valid (state == LATCH_AREA),
        .divisor_data  (area_r),
        .result_valid  (area_inv_valid),
        .result_data   (area_inv)
    );

endmodule

/* verilog/triangle_setup.sv */
`timescale 1ns/1ps

module triangle_setup import raster_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 vertex_s_valid,
    output logic                 vertex_s_ready,
    input  vertex_t              vertex_s_data,
    input  logic                 vertex_s_last,

    input  logic                 attributed_triangle_m_ready,
    output logic                 attributed_triangle_m_valid,
    output attributed_triangle_t attributed_triangle_m_data,
    output triangle_metadata_t   attributed_triangle_m_metadata
);

    logic           item_valid;
    logic           item_ready;
    triangle_item_t item_data;

    logic           queued_valid;
    logic           queued_ready;
    triangle_item_t queued_data;

    triangle_assembler assembler (
        .clk            (clk),
        .rstn           (rstn),
        .vertex_s_valid (vertex_s_valid),
        .vertex_s_ready (vertex_s_ready),
        .vertex_s_data  (vertex_s_data),
        .vertex_s_last  (vertex_s_last),
        .item_ready     (item_ready),
        .item_valid     (item_valid),
        .item_data      (item_data)
    );

    triangle_fifo #(
        .payload_t (triangle_item_t),
        .DEPTH     (FIFO_DEPTH)
    ) fifo (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (item_valid),
        .in_ready  (item_ready),
        .in_data   (item_data),
        .out_valid (queued_valid),
        .out_ready (queued_ready),
        .out_data  (queued_data)
    );

    triangle_preprocessor preprocessor (
        .clk                            (clk),
        .rstn                           (rstn),
        .triangle_s_ready               (queued_ready),
        .triangle_s_valid               (queued_valid),
        .triangle_s_data                (queued_data),
        .attributed_triangle_m_ready    (attributed_triangle_m_ready),
        .attributed_triangle_m_valid    (attributed_triangle_m_valid),
        .attributed_triangle_m_data     (attributed_triangle_m_data),
        .attributed_triangle_m_metadata (attributed_triangle_m_metadata)
    );

endmodule

/* bench/tb_triangle_setup.sv */
`timescale 1ns/1ps

module tb_triangle_setup import raster_pkg::*; ();

    localparam int          NUM_ROWS   = 13;
    localparam int          FIFO_DEPTH = 4;
    localparam int          TIMEOUT    = 2000;       // Cycles allowed for any single wait.
    localparam logic [31:0] SEED       = 32'd32516;

    logic                 clk;
    logic                 rstn;
    logic                 vertex_s_valid;
    logic                 vertex_s_ready;
    vertex_t              vertex_s_data;
    logic                 vertex_s_last;
    logic                 attributed_triangle_m_ready;
    logic                 attributed_triangle_m_valid;
    attributed_triangle_t attributed_triangle_m_data;
    triangle_metadata_t   attributed_triangle_m_metadata;

    triangle_t   tri_table [NUM_ROWS];
    logic        last_table [NUM_ROWS];
    fixed        inv_table [NUM_ROWS];               // Expected area_inv per row.
    int          row_count;
    int          mismatch_count;
    int          protocol_count;
    int          timeout_count;
    logic        timed_out;
    logic [31:0] gap_rng;
    logic [31:0] ready_rng;

    triangle_setup #(.FIFO_DEPTH(FIFO_DEPTH)) dut (
        .clk                            (clk),
        .rstn                           (rstn),
        .vertex_s_valid                 (vertex_s_valid),
        .vertex_s_ready                 (vertex_s_ready),
        .vertex_s_data                  (vertex_s_data),
        .vertex_s_last                  (vertex_s_last),
        .attributed_triangle_m_ready    (attributed_triangle_m_ready),
        .attributed_triangle_m_valid    (attributed_triangle_m_valid),
        .attributed_triangle_m_data     (attributed_triangle_m_data),
        .attributed_triangle_m_metadata (attributed_triangle_m_metadata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                      // 20 ns period.
    end

    function automatic logic [31:0] xorshift32(logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic fixed fx(real value);
        return fixed'($rtoi(value * 65536.0));       // Truncates the unrepresentable tail.
    endfunction

    function automatic fixed model_mul(fixed a, fixed b);
        longint product;
        product = longint'(a) * longint'(b);
        return fixed'(product >>> 16);               // Floors toward minus infinity.
    endfunction

    function automatic fixed model_area(triangle_t t);
        fixed x0;
        fixed y0;
        fixed x1;
        fixed y1;
        fixed x2;
        fixed y2;
        x0 = t.v0.position.x;
        y0 = t.v0.position.y;
        x1 = t.v1.position.x;
        y1 = t.v1.position.y;
        x2 = t.v2.position.x;
        y2 = t.v2.position.y;
        return model_mul(y1 - y2, x0) + model_mul(y2 - y0, x1) + model_mul(y0 - y1, x2);
    endfunction

    // One in Q16.16 shifted by 16 more bits, over the area.
    function automatic fixed model_inverse(fixed area);
        longint quotient;
        if (area == 0) begin
            return FIXED_MAX;
        end
        quotient = (longint'(1) <<< 32) / longint'(area);   // Truncates toward zero.
        if (quotient > 64'sh7FFF_FFFF) begin
            return FIXED_MAX;
        end
        if (quotient < -64'sh8000_0000) begin
            return FIXED_MIN;
        end
        return fixed'(quotient);
    endfunction

    task automatic add_row(fixed x0, fixed y0, fixed x1, fixed y1,
                           fixed x2, fixed y2, logic last);
        triangle_t t;
        t.v0.position.x = x0;
        t.v0.position.y = y0;
        t.v1.position.x = x1;
        t.v1.position.y = y1;
        t.v2.position.x = x2;
        t.v2.position.y = y2;
        tri_table[row_count]  = t;
        last_table[row_count] = last;
        inv_table[row_count]  = model_inverse(model_area(t));
        row_count++;
    endtask

    task automatic build_table();
        add_row(fx(0.0), fx(0.0), fx(1.0), fx(0.0), fx(0.0), fx(1.0), 1'b0);
        add_row(fx(0.0), fx(0.0), fx(0.0), fx(1.0), fx(1.0), fx(0.0), 1'b0);      // Clockwise.
        add_row(fx(0.5), fx(0.25), fx(3.75), fx(1.5), fx(1.25), fx(4.0), 1'b0);
        add_row(fx(-60.0), fx(-50.0), fx(70.0), fx(-40.0), fx(5.0), fx(80.0), 1'b1);
        add_row(fx(0.0), fx(0.0), fx(1.0), fx(1.0), fx(2.0), fx(2.0), 1'b0);      // Collinear.
        add_row(fx(0.0), fx(0.0), fx(1.0), fx(0.0), fx(0.0), 32'hFFFF_FFFF, 1'b0); // Area -1 lsb.
        add_row(fx(0.0), fx(0.0), fx(1.0), fx(0.0), fx(0.0), 32'h0000_0001, 1'b0);
        add_row(fx(0.0), fx(0.0), fx(-1.0), fx(0.0), fx(0.0), 32'h0000_0002, 1'b0);
        add_row(fx(-1.3), fx(2.7), fx(4.1), fx(-0.6), fx(-2.2), fx(-3.9), 1'b0);
        add_row(fx(10.0), fx(20.0), fx(-30.0), fx(25.0), fx(40.0), fx(-35.0), 1'b1);
        add_row(fx(0.0), fx(0.0), fx(2.0), fx(0.0), fx(0.0), fx(2.0), 1'b0);
        add_row(fx(1.0), fx(1.0), fx(1.0), fx(1.0), fx(1.0), fx(1.0), 1'b0);      // One point.
        add_row(fx(-0.75), fx(0.5), fx(0.25), fx(-1.5), fx(2.5), fx(3.25), 1'b1);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer.
    task automatic send_vertex(vertex_t v, logic last);
        int waited;
        vertex_s_valid = 1'b1;
        vertex_s_data  = v;
        vertex_s_last  = last;
        waited = 0;
        while (!vertex_s_ready && !timed_out && waited <= TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (waited <= TIMEOUT) else begin
            timeout_count++;
            timed_out = 1'b1;
            $display("Timeout: vertex_s_ready stayed low for %0d cycles", TIMEOUT);
        end
        @(negedge clk);
        vertex_s_valid = 1'b0;
    endtask

    task automatic drive_rows();
        int      gap;
        vertex_t v;
        for (int row = 0; row < NUM_ROWS && !timed_out; row++) begin
            for (int j = 0; j < 3; j++) begin
                gap_rng = xorshift32(gap_rng);
                gap = int'(gap_rng % 32'd3);
                repeat (gap) @(negedge clk);
                case (j)
                    0:       v = tri_table[row].v0;
                    1:       v = tri_table[row].v1;
                    default: v = tri_table[row].v2;
                endcase
                // Last flag is inverted on the first two vertices, which must be ignored.
                send_vertex(v, (j == 2) ? last_table[row] : !last_table[row]);
            end
        end
    endtask

    task automatic check_output(int row);
        attributed_triangle_t got;
        triangle_metadata_t   meta;
        got  = attributed_triangle_m_data;
        meta = attributed_triangle_m_metadata;
        assert (got.area_inv == inv_table[row]) else begin
            mismatch_count++;
            $display("MISMATCH attributed_triangle_m_data.area_inv row %0d: got %h expected %h",
                     row, got.area_inv, inv_table[row]);
        end
        assert (got.triangle == tri_table[row]) else begin
            mismatch_count++;
            $display("MISMATCH attributed_triangle_m_data.triangle row %0d: got %h expected %h",
                     row, got.triangle, tri_table[row]);
        end
        assert (meta.id == 16'(row)) else begin
            mismatch_count++;
            $display("MISMATCH attributed_triangle_m_metadata.id: got %h expected %h",
                     meta.id, 16'(row));
        end
        assert (meta.end_of_mesh == last_table[row]) else begin
            mismatch_count++;
            $display("MISMATCH attributed_triangle_m_metadata.end_of_mesh row %0d: got %h expected %h",
                     row, meta.end_of_mesh, last_table[row]);
        end
    endtask

    task automatic collect_rows();
        int                   row;
        int                   idle;
        logic                 held;
        attributed_triangle_t held_data;
        triangle_metadata_t   held_meta;
        row  = 0;
        idle = 0;
        held = 1'b0;
        while (row < NUM_ROWS && !timed_out) begin
            @(negedge clk);
            if (held) begin
                assert (attributed_triangle_m_valid && attributed_triangle_m_data == held_data
                        && attributed_triangle_m_metadata == held_meta) else begin
                    protocol_count++;
                    $display("Output changed while stalled by ready, row %0d", row);
                end
            end
            ready_rng = xorshift32(ready_rng);
            attributed_triangle_m_ready = (ready_rng[1:0] != 2'b00);   // Ready three in four.
            if (attributed_triangle_m_valid && attributed_triangle_m_ready) begin
                check_output(row);
                row++;
                idle = 0;
                held = 1'b0;
            end else begin
                held      = attributed_triangle_m_valid;
                held_data = attributed_triangle_m_data;
                held_meta = attributed_triangle_m_metadata;
                idle++;
                assert (idle <= TIMEOUT) else begin
                    timeout_count++;
                    timed_out = 1'b1;
                    $display("Timeout: no output triangle for row %0d", row);
                end
            end
        end
    endtask

    task automatic check_quiet();
        attributed_triangle_m_ready = 1'b1;
        repeat (60) begin
            @(negedge clk);
            assert (!attributed_triangle_m_valid) else begin
                protocol_count++;
                $display("Unexpected extra triangle on the output");
            end
        end
    endtask

    initial begin
        rstn                        = 1'b0;
        vertex_s_valid              = 1'b0;
        vertex_s_data               = '0;
        vertex_s_last               = 1'b0;
        attributed_triangle_m_ready = 1'b0;
        mismatch_count              = 0;
        protocol_count              = 0;
        timeout_count               = 0;
        timed_out                   = 1'b0;
        row_count                   = 0;
        gap_rng                     = SEED;
        ready_rng                   = xorshift32(xorshift32(SEED));   // Separate stream.
        build_table();

        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (!attributed_triangle_m_valid && vertex_s_ready) else begin
            protocol_count++;
            $display("Handshake outputs not idle after reset");
        end

        fork
            drive_rows();
            collect_rows();
        join
        if (!timed_out) begin
            check_quiet();
        end

        $display("Errors: %0d mismatch, %0d protocol, %0d timeout",
                 mismatch_count, protocol_count, timeout_count);
        if (mismatch_count + protocol_count + timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/raster_pkg.sv
verilog/triangle_assembler.sv
verilog/triangle_fifo.sv
verilog/fixed_divider.sv
verilog/triangle_preprocessor.sv
verilog/triangle_setup.sv
bench/tb_triangle_setup.sv

/* Makefile */
SIM     := obj_dir/Vtb_triangle_setup
SOURCES := $(shell cat tb.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): tb.f $(SOURCES)
	verilator --binary --assert --top-module tb_triangle_setup -f tb.f -o Vtb_triangle_setup

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
